/* design/fadc_defines.svh */
/* Widths, FIFO depth, record length limits and the source
   identifier for the fast-ADC trigger capture path */

`ifndef FADC_DEFINES_SVH
`define FADC_DEFINES_SVH

//////////////////////////////
// Data widths
//////////////////////////////

`define FADC_SAMPLE_W 14 // ADC channel 0 resolution
`define FADC_WORD_W 32 // Flag + id + two samples

//////////////////////////////
// Buffering and frames
//////////////////////////////

`define FADC_FIFO_DEPTH 16 // Event FIFO entries, power of two
`define FADC_REC_LEN_W 8
`define FADC_REC_LEN_MIN 8'd2 // Shortest frame, one word

// Tag of the ADC channel in every header word
`define FADC_SOURCE_ID 3'd3

`endif

/* design/fadc_pkg.sv */
/* Shared types: ADC sample, packed output word,
   record length and trigger mode */

`include "fadc_defines.svh"

package fadc_pkg;

    // One raw ADC sample
    typedef logic [`FADC_SAMPLE_W-1:0] sample_t;

    // Output word layout
    //   [31]    frame start
    //   [30:28] source id, first word only
    //   [27:14] earlier sample
    //   [13:0]  later sample
    typedef logic [`FADC_WORD_W-1:0] word_t;

    // Samples per frame, bit 0 ignored
    typedef logic [`FADC_REC_LEN_W-1:0] rec_len_t;

    // Trigger source select
    typedef enum logic
    {
        TRIG_GATE      = 1'b0, // Rising edge of the external gate
        TRIG_THRESHOLD = 1'b1  // Sample drops below threshold
    } trig_mode_e;

endpackage

/* design/fadc_trigger_select.sv */
/* Trigger selector: threshold crossing and gate edge detection,
   registered together with the sample */

`timescale 1ns/1ps

module fadc_trigger_select
(
    input  logic                 ADC_ENC,
    input  logic                 i_arst_n,
    input  fadc_pkg::sample_t    i_adc_sample,
    input  logic                 i_gate,
    input  fadc_pkg::trig_mode_e i_trig_mode,
    input  fadc_pkg::sample_t    i_threshold,
    output fadc_pkg::sample_t    o_sample,
    output logic                 o_trig
);

    logic below;     // Current sample under threshold
    logic below_q;   // Same, one sample earlier
    logic gate_q;    // Previous gate level
    logic thr_evt;
    logic gate_evt;
    logic trig;

    //////////////////////////////
    // Event detection
    //////////////////////////////

    assign below    = i_adc_sample < i_threshold;
    assign thr_evt  = below & ~below_q;   // Downward crossing only
    assign gate_evt = i_gate & ~gate_q;   // Rising edge

    assign trig = (i_trig_mode == fadc_pkg::TRIG_THRESHOLD) ? thr_evt : gate_evt;

    always_ff @(posedge ADC_ENC or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            below_q <= 1'b0;
            gate_q  <= 1'b0;
            o_trig  <= 1'b0;
        end
        else
        begin
            below_q <= below;
            gate_q  <= i_gate;
            o_trig  <= trig;
        end
    end

    // Sample follows its trigger flag by the same one cycle
    always_ff @(posedge ADC_ENC)
    begin
        o_sample <= i_adc_sample;
    end

endmodule

/* design/fadc_frame_packer.sv */
/* Frame packer: collects a record of samples after a trigger
   and packs them two per word, header flag on the first */

`timescale 1ns/1ps

`include "fadc_defines.svh"

module fadc_frame_packer
(
    input  logic               ADC_ENC,
    input  logic               i_arst_n,
    input  fadc_pkg::sample_t  i_sample,
    input  logic               i_trig,
    input  fadc_pkg::rec_len_t i_record_len,
    output logic               o_wr,
    output fadc_pkg::word_t    o_word
);

    logic               active_q;   // Frame in progress
    logic               first_q;    // Next word is the header word
    fadc_pkg::rec_len_t remain_q;   // Samples still to come
    fadc_pkg::rec_len_t start_len;
    fadc_pkg::sample_t  hold_q;     // Earlier sample of the pair
    logic               pair_done;

    // Odd lengths rounded down
    assign start_len = {i_record_len[`FADC_REC_LEN_W-1:1], 1'b0};

    // Remaining count is odd while the second sample of a pair arrives
    assign pair_done = active_q & remain_q[0];

    //////////////////////////////
    // Frame control
    //////////////////////////////

    always_ff @(posedge ADC_ENC or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            active_q <= 1'b0;
            first_q  <= 1'b0;
            remain_q <= '0;
            o_wr     <= 1'b0;
        end
        else
        begin
            o_wr <= 1'b0;
            if (!active_q)
            begin
                // Triggering sample is the first of the frame
                if (i_trig && start_len >= `FADC_REC_LEN_MIN)
                begin
                    active_q <= 1'b1;
                    first_q  <= 1'b1;
                    remain_q <= start_len - 1'b1;
                end
            end
            else
            begin
                remain_q <= remain_q - 1'b1;
                if (remain_q[0])
                begin
                    o_wr    <= 1'b1;
                    first_q <= 1'b0;
                end
                if (remain_q == fadc_pkg::rec_len_t'(1))
                    active_q <= 1'b0; // Last sample, idle again next cycle
            end
        end
    end

    //////////////////////////////
    // Packing
    //////////////////////////////

    always_ff @(posedge ADC_ENC)
    begin
        if (!pair_done)
            hold_q <= i_sample;
        if (pair_done)
            o_word <= {first_q, first_q ? `FADC_SOURCE_ID : 3'd0, hold_q, i_sample};
    end

endmodule

/* design/fadc_event_fifo.sv */
/* Event FIFO: circular word buffer that drops writes when full
   and keeps a sticky lost-data flag */

`timescale 1ns/1ps

`include "fadc_defines.svh"

module fadc_event_fifo
(
    input  logic            ADC_ENC,
    input  logic            i_arst_n,
    input  logic            i_wr,
    input  fadc_pkg::word_t i_word,
    input  logic            i_pop,
    output logic            o_not_empty,
    output fadc_pkg::word_t o_head,
    output logic            o_lost_error
);

    localparam int DEPTH = `FADC_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    fadc_pkg::word_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // Fill level, 0 to DEPTH
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full        = count == (AW+1)'(DEPTH);
    assign do_wr       = i_wr & ~full;
    assign do_rd       = i_pop & o_not_empty;
    assign o_not_empty = count != '0;
    assign o_head      = mem[rd_ptr]; // Head readable without a pop

    always_ff @(posedge ADC_ENC or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            o_lost_error <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
            if (i_wr && full)
                o_lost_error <= 1'b1; // Sticky until reset
        end
    end

    always_ff @(posedge ADC_ENC)
    begin
        if (do_wr)
            mem[wr_ptr] <= i_word;
    end

endmodule

/* design/fadc_req_ack_sender.sv */
/* Output stage: loads the FIFO head and delivers it over a
   four-phase req/ack handshake */

`timescale 1ns/1ps

module fadc_req_ack_sender
(
    input  logic            ADC_ENC,
    input  logic            i_arst_n,
    input  logic            i_not_empty,
    input  fadc_pkg::word_t i_head,
    input  logic            i_ack,
    output logic            o_pop,
    output logic            o_req,
    output fadc_pkg::word_t o_data
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_REQ,      // Request up, waiting for ack
        S_RELEASE   // Request down, waiting for ack low
    } state_e;

    state_e state_q;

    // Load a word only when no transfer is pending
    assign o_pop = i_not_empty &
                   ((state_q == S_IDLE) | ((state_q == S_RELEASE) & ~i_ack));
    assign o_req = state_q == S_REQ;

    always_ff @(posedge ADC_ENC or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state_q <= S_IDLE;
        else
        begin
            case (state_q)
                S_IDLE:    if (i_not_empty) state_q <= S_REQ;
                S_REQ:     if (i_ack) state_q <= S_RELEASE;
                S_RELEASE: if (!i_ack) state_q <= i_not_empty ? S_REQ : S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    // Data register, stable for the whole request phase
    always_ff @(posedge ADC_ENC)
    begin
        if (o_pop)
            o_data <= i_head;
    end

endmodule

/* design/fadc_trigger_capture.sv */
/* Top level of the triggered fast-ADC readout path:
   trigger selector, frame packer, event FIFO and sender */

`timescale 1ns/1ps

module fadc_trigger_capture
(
    input  logic                 ADC_ENC,
    input  logic                 i_arst_n,
    input  fadc_pkg::sample_t    i_adc_sample,
    input  logic                 i_gate,
    input  fadc_pkg::trig_mode_e i_trig_mode,
    input  fadc_pkg::sample_t    i_threshold,
    input  fadc_pkg::rec_len_t   i_record_len,
    output logic                 o_req,
    output fadc_pkg::word_t      o_data,
    input  logic                 i_ack,
    output logic                 o_lost_error
);

    fadc_pkg::sample_t sel_sample;   // Selector to packer
    logic              sel_trig;
    logic              pk_wr;        // Packer to FIFO
    fadc_pkg::word_t   pk_word;
    logic              fifo_not_empty;
    fadc_pkg::word_t   fifo_head;
    logic              snd_pop;

    //////////////////////////////
    // Trigger and framing
    //////////////////////////////

    fadc_trigger_select trigger_select_i
    (
        .ADC_ENC      (ADC_ENC),
        .i_arst_n     (i_arst_n),
        .i_adc_sample (i_adc_sample),
        .i_gate       (i_gate),
        .i_trig_mode  (i_trig_mode),
        .i_threshold  (i_threshold),
        .o_sample     (sel_sample),
        .o_trig       (sel_trig)
    );

    fadc_frame_packer frame_packer_i
    (
        .ADC_ENC      (ADC_ENC),
        .i_arst_n     (i_arst_n),
        .i_sample     (sel_sample),
        .i_trig       (sel_trig),
        .i_record_len (i_record_len),
        .o_wr         (pk_wr),
        .o_word       (pk_word)
    );

    //////////////////////////////
    // Buffer and output
    //////////////////////////////

    fadc_event_fifo event_fifo_i
    (
        .ADC_ENC      (ADC_ENC),
        .i_arst_n     (i_arst_n),
        .i_wr         (pk_wr),
        .i_word       (pk_word),
        .i_pop        (snd_pop),
        .o_not_empty  (fifo_not_empty),
        .o_head       (fifo_head),
        .o_lost_error (o_lost_error)
    );

    fadc_req_ack_sender req_ack_sender_i
    (
        .ADC_ENC     (ADC_ENC),
        .i_arst_n    (i_arst_n),
        .i_not_empty (fifo_not_empty),
        .i_head      (fifo_head),
        .i_ack       (i_ack),
        .o_pop       (snd_pop),
        .o_req       (o_req),
        .o_data      (o_data)
    );

endmodule

/* test/fadc_trigger_capture_checker.sv */
/* Concurrent assertions on the req/ack handshake and the
   sticky lost-data flag of the event FIFO */

`timescale 1ns/1ps

module fadc_trigger_capture_checker
(
    input logic            ADC_ENC,
    input logic            i_arst_n,
    input logic            o_req,
    input fadc_pkg::word_t o_data,
    input logic            i_ack,
    input logic            o_lost_error
);

    // Word held for the whole request phase
    data_stable: assert property (@(posedge ADC_ENC) disable iff (!i_arst_n)
        o_req && !i_ack |=> $stable(o_data))
        else $error("o_data changed while o_req waited for i_ack");

    data_known: assert property (@(posedge ADC_ENC) disable iff (!i_arst_n)
        o_req |-> !$isunknown(o_data))
        else $error("o_data unknown during a request");

    // No new request until the previous ack is released
    req_after_release: assert property (@(posedge ADC_ENC) disable iff (!i_arst_n)
        !o_req && i_ack |=> !o_req)
        else $error("o_req rose while i_ack was still high");

    lost_sticky: assert property (@(posedge ADC_ENC) disable iff (!i_arst_n)
        o_lost_error |=> o_lost_error)
        else $error("o_lost_error fell without reset");

endmodule

/* test/fadc_trigger_capture_tb.sv */
/* Testbench for the fast-ADC trigger capture path with stimulus log,
   reference model, req/ack responder, watchdog and summary */

`timescale 1ns/1ps

`include "fadc_defines.svh"

module fadc_trigger_capture_tb;

    localparam int LOG_MAX       = 1400;
    localparam int ACK_DELAY_MAX = 3;
    localparam int WORD_COST     = 2 * ACK_DELAY_MAX + 4; // Worst cycles per handshake
    localparam int KEEP_ALL      = 1 << 30;
    localparam int KEEP_OVERFLOW = `FADC_FIFO_DEPTH + 1;  // FIFO plus sender register
    localparam int DRAIN_MAX     = (KEEP_OVERFLOW + 2) * WORD_COST + 40;
    localparam fadc_pkg::sample_t THR  = 14'h1000;
    localparam fadc_pkg::sample_t IDLE = 14'h3FFF;        // Never below any threshold

    logic                 ADC_ENC;
    logic                 i_arst_n;
    fadc_pkg::sample_t    i_adc_sample;
    logic                 i_gate;
    fadc_pkg::trig_mode_e i_trig_mode;
    fadc_pkg::sample_t    i_threshold;
    fadc_pkg::rec_len_t   i_record_len;
    logic                 o_req;
    fadc_pkg::word_t      o_data;
    logic                 i_ack;
    logic                 o_lost_error;

    // Stimulus log with one entry per driven sample
    fadc_pkg::sample_t    s_log [LOG_MAX];
    logic                 g_log [LOG_MAX];
    fadc_pkg::trig_mode_e m_log [LOG_MAX];
    fadc_pkg::sample_t    t_log [LOG_MAX];
    fadc_pkg::rec_len_t   r_log [LOG_MAX];
    int                   n_log;
    int                   seg1_end;
    int                   seg1_words;
    int                   total_words;

    fadc_pkg::word_t exp_q [$];
    logic [31:0]     stim_state;
    logic [31:0]     ack_state;
    int              errors;
    int              checks;
    int              n_recv;
    int              ack_wait;
    int              rel_wait;
    logic            hold_ack;      // Responder stays silent under back-pressure
    logic            plan_done;

    fadc_trigger_capture dut_i
    (
        .ADC_ENC      (ADC_ENC),
        .i_arst_n     (i_arst_n),
        .i_adc_sample (i_adc_sample),
        .i_gate       (i_gate),
        .i_trig_mode  (i_trig_mode),
        .i_threshold  (i_threshold),
        .i_record_len (i_record_len),
        .o_req        (o_req),
        .o_data       (o_data),
        .i_ack        (i_ack),
        .o_lost_error (o_lost_error)
    );

    bind fadc_trigger_capture fadc_trigger_capture_checker checker_i
    (
        .ADC_ENC      (ADC_ENC),
        .i_arst_n     (i_arst_n),
        .o_req        (o_req),
        .o_data       (o_data),
        .i_ack        (i_ack),
        .o_lost_error (o_lost_error)
    );

    initial
    begin
        ADC_ENC = 1'b0;
        forever #10 ADC_ENC = ~ADC_ENC;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic add_sample(input fadc_pkg::sample_t s, input logic g,
                              input fadc_pkg::trig_mode_e m, input fadc_pkg::sample_t t,
                              input fadc_pkg::rec_len_t r);
        s_log[n_log] = s;
        g_log[n_log] = g;
        m_log[n_log] = m;
        t_log[n_log] = t;
        r_log[n_log] = r;
        n_log++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
        end
    endtask

    // Expected words of log entries first..last-1 up to keep words
    function automatic void build_expected(input int first, input int last, input int keep);
        logic prev_below;
        logic prev_gate;
        logic below;
        logic trig;
        logic in_frame;
        logic head;
        int remain;
        int len;
        int added;
        int k;
        fadc_pkg::sample_t held;
        fadc_pkg::word_t word;
        prev_below = 1'b0;
        prev_gate  = 1'b0;
        in_frame   = 1'b0;
        head       = 1'b0;
        remain     = 0;
        added      = 0;
        held       = '0;
        for (k = first; k < last; k++)
        begin
            below = s_log[k] < t_log[k];
            if (m_log[k] == fadc_pkg::TRIG_THRESHOLD)
                trig = below && !prev_below;
            else
                trig = g_log[k] && !prev_gate;
            prev_below = below;
            prev_gate  = g_log[k];
            // Length is read when the triggering sample reaches the packer
            len = (int'(r_log[k + 1]) / 2) * 2;
            if (!in_frame && trig && len >= 2)
            begin
                in_frame = 1'b1;
                head     = 1'b1;
                remain   = len;
            end
            if (in_frame)
            begin
                if (remain % 2 == 0)
                    held = s_log[k];
                else
                begin
                    word        = '0;
                    word[31]    = head;          // Frame start
                    if (head)
                        word[30:28] = `FADC_SOURCE_ID;
                    word[27:14] = held;          // Earlier sample
                    word[13:0]  = s_log[k];
                    if (added < keep)
                        exp_q.push_back(word);
                    added++;
                    head = 1'b0;
                end
                remain--;
                in_frame = remain != 0;
            end
        end
    endfunction

    task automatic gen_stimulus();
        logic [31:0] r;
        fadc_pkg::rec_len_t rl;
        fadc_pkg::sample_t smp;
        int i;
        int n;
        for (i = 0; i < 16; i++)
            add_sample(IDLE, i[1], fadc_pkg::TRIG_THRESHOLD, THR, 8'd4); // Gate ignored
        // Threshold ramps down with a bounce and the length changes after the ramp
        for (n = 0; n < 10; n++)
        begin
            rl = fadc_pkg::rec_len_t'(2 + (lcg_next(stim_state) >> 16) % 15);
            for (i = 0; i < 14; i++)
            begin
                if (i == 12)
                    smp = 14'h1800;
                else if (i == 13)
                    smp = 14'h0800;
                else
                    smp = 14'h1400 - fadc_pkg::sample_t'(i * 128);
                add_sample(smp, 1'b0, fadc_pkg::TRIG_THRESHOLD, THR, rl);
            end
            rl = fadc_pkg::rec_len_t'(2 + (lcg_next(stim_state) >> 16) % 15);
            for (i = 0; i < 60; i++)
            begin
                r   = lcg_next(stim_state);
                smp = THR + fadc_pkg::sample_t'(r[31:16] % 16'h3000);
                add_sample(smp, r[20], fadc_pkg::TRIG_THRESHOLD, THR, rl);
            end
        end
        // Gate mode with random samples crossing the threshold freely
        for (n = 0; n < 8; n++)
        begin
            rl = fadc_pkg::rec_len_t'(2 + (lcg_next(stim_state) >> 16) % 15);
            for (i = 0; i < 60; i++)
            begin
                r = lcg_next(stim_state);
                if (i == 20)
                    rl = fadc_pkg::rec_len_t'(2 + (r >> 16) % 15);
                add_sample(r[29:16], (i >= 2 && i < 5) || i == 9, fadc_pkg::TRIG_GATE,
                           14'h2000, rl);
            end
        end
        for (i = 0; i < 24; i++)
            add_sample(IDLE, 1'b0, fadc_pkg::TRIG_GATE, THR, rl);
        seg1_end = n_log;
        // Overflow run of three frames with eight words each
        for (n = 0; n < 3; n++)
            for (i = 0; i < 20; i++)
            begin
                r = lcg_next(stim_state);
                add_sample(r[29:16], i == 1 || i == 2, fadc_pkg::TRIG_GATE, THR, 8'd16);
            end
        for (i = 0; i < 24; i++)
            add_sample(IDLE, 1'b0, fadc_pkg::TRIG_GATE, THR, 8'd16);
    endtask

    task automatic drive_range(input int first, input int last);
        int k;
        for (k = first; k < last; k++)
        begin
            @(negedge ADC_ENC);
            i_adc_sample = s_log[k];
            i_gate       = g_log[k];
            i_trig_mode  = m_log[k];
            i_threshold  = t_log[k];
            i_record_len = r_log[k];
        end
    endtask

    task automatic wait_drain(input int target);
        int cycles;
        cycles = 0;
        while ((n_recv < target || i_ack || o_req) && cycles < DRAIN_MAX)
        begin
            @(negedge ADC_ENC);
            cycles++;
        end
        if (n_recv < target)
        begin
            errors++;
            $display("Only %0d of %0d words arrived before the drain limit", n_recv, target);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        i_arst_n     = 1'b0;
        i_adc_sample = IDLE;
        i_gate       = 1'b0;
        i_trig_mode  = fadc_pkg::TRIG_THRESHOLD;
        i_threshold  = THR;
        i_record_len = 8'd4;
        hold_ack     = 1'b0;
        plan_done    = 1'b0;
        errors       = 0;
        checks       = 0;
        n_log        = 0;
        stim_state   = 32'd93724;
        gen_stimulus();
        build_expected(0, seg1_end, KEEP_ALL);
        seg1_words = exp_q.size();
        build_expected(seg1_end, n_log, KEEP_OVERFLOW);
        total_words = exp_q.size();
        plan_done   = 1'b1;
        repeat (2) @(posedge ADC_ENC);
        @(negedge ADC_ENC);
        i_arst_n = 1'b1;
        check_value("o_req", 32'(o_req), 32'd0);
        check_value("o_lost_error", 32'(o_lost_error), 32'd0);
        drive_range(0, seg1_end);
        wait_drain(seg1_words);
        check_value("o_lost_error", 32'(o_lost_error), 32'd0);
        hold_ack = 1'b1;
        drive_range(seg1_end, n_log);
        check_value("o_lost_error", 32'(o_lost_error), 32'd1);
        hold_ack = 1'b0;
        wait_drain(total_words);
        repeat (40) @(negedge ADC_ENC); // Room for stray words
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected words never arrived", exp_q.size());
        end
        $display("Checks %0d, errors %0d, words received %0d of %0d",
                 checks, errors, n_recv, total_words);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Ack side of the handshake that compares each delivered word
    initial
    begin
        i_ack     = 1'b0;
        n_recv    = 0;
        ack_wait  = 0;
        rel_wait  = 0;
        ack_state = 32'd93724;
        forever
        begin
            @(negedge ADC_ENC);
            if (i_arst_n && !hold_ack)
            begin
                if (i_ack && !o_req && rel_wait > 0)
                    rel_wait--;          // Ack held after o_req has dropped
                else if (i_ack && !o_req)
                    i_ack = 1'b0;
                else if (!i_ack && o_req && ack_wait > 0)
                    ack_wait--;
                else if (!i_ack && o_req)
                begin
                    if (exp_q.size() == 0)
                    begin
                        errors++;
                        $display("Unexpected word 0x%08h on o_data", o_data);
                    end
                    else
                        check_value("o_data", o_data, exp_q.pop_front());
                    n_recv++;
                    i_ack    = 1'b1;
                    ack_wait = int'((lcg_next(ack_state) >> 16) % (ACK_DELAY_MAX + 1));
                    rel_wait = int'((lcg_next(ack_state) >> 16) % (ACK_DELAY_MAX + 1));
                end
            end
        end
    end

    initial
    begin
        int limit;
        wait (plan_done);
        limit = 2 * (n_log + total_words * WORD_COST + 64);
        repeat (limit) @(posedge ADC_ENC);
        $display("Watchdog expired after %0d cycles, %0d words still expected",
                 limit, exp_q.size());
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* fadc_trigger_capture.f */
+incdir+design
design/fadc_pkg.sv
design/fadc_trigger_select.sv
design/fadc_frame_packer.sv
design/fadc_event_fifo.sv
design/fadc_req_ack_sender.sv
design/fadc_trigger_capture.sv
test/fadc_trigger_capture_checker.sv
test/fadc_trigger_capture_tb.sv

/* Makefile */
# Verilator build and run of the fast-ADC trigger capture testbench

VERILATOR ?= verilator
TB_TOP    ?= fadc_trigger_capture_tb
FILELIST  ?= fadc_trigger_capture.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(wildcard design/*.sv design/*.svh test/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
